/* common/uart_consts.svh */
// UART constants
// Register map, reset divisor, FIFO depth and control bit positions
// shared by the register bank, the register word types and the top level

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// two-bit register addresses as seen on the bus
`define UART_ADDR_SETUP 2'd0
`define UART_ADDR_FIFO 2'd1
`define UART_ADDR_RXREG 2'd2
`define UART_ADDR_TXREG 2'd3

// clocks per bit out of reset
`define UART_DEFAULT_DIV 24'd25

// log2 of the depth of each FIFO
`define UART_LGFLEN 4

// engine reset request in a receive or transmit register write
`define UART_RST_BIT 12

// framing error, read from and cleared through the receive register
`define UART_FERR_BIT 10

`endif

/* common/uart_line_pkg.sv */
// UART line-side types
// Data bytes, baud divisor, FIFO status word and the receiver's byte event

`default_nettype none

package uart_line_pkg;

	// one data byte as it travels on the line
	typedef logic [7:0] uart_byte_t;

	// clocks per bit
	typedef logic [23:0] baud_div_t;

	// FIFO status, one half of the FIFO register
	// count is the fill for the receive FIFO and the free space for transmit
	typedef struct packed {
		logic [3:0] lg_len;
		logic [9:0] count;
		logic half;
		logic ready;
	} fifo_status_t;

	// one received frame, stb is a single clock pulse and the rest is payload
	typedef struct packed {
		logic stb;
		logic ferr;
		uart_byte_t data;
	} rx_event_t;

endpackage

`default_nettype wire

/* common/uart_regs_pkg.sv */
// UART bus-side types
// Bus request bundle and the layouts of the words written to and read
// from the four registers

`default_nettype none

`include "uart_consts.svh"

package uart_regs_pkg;

	// pipelined bus request, all fields sampled on the same clock
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [1:0] addr;
		logic [3:0] sel;
		logic [31:0] data;
	} wb_req_t;

	// setup register, only the divisor is kept
	typedef struct packed {
		logic [7:0] zero;
		uart_line_pkg::baud_div_t div;
	} setup_word_t;

	// write to the receive or transmit register
	typedef struct packed {
		logic [31:(`UART_RST_BIT+1)] rsvd_hi;
		logic rst;
		logic [(`UART_RST_BIT-1):(`UART_FERR_BIT+1)] rsvd_mid;
		logic ferr_clr;
		logic [(`UART_FERR_BIT-1):8] rsvd_lo;
		uart_line_pkg::uart_byte_t data;
	} ctl_word_t;

	// the same write word seen as a setup word or as a data/control word,
	// which view applies depends on the address of the strobe
	typedef union packed {
		setup_word_t setup;
		ctl_word_t ctl;
	} reg_word_u;

	// read of the receive register
	typedef struct packed {
		logic [31:(`UART_RST_BIT+1)] rsvd_hi;
		logic fifo_err;
		logic [(`UART_RST_BIT-1):(`UART_FERR_BIT+1)] rsvd_mid;
		logic ferr;
		logic rsvd_lo;
		logic empty;
		uart_line_pkg::uart_byte_t data;
	} rx_read_t;

	// read of the transmit register
	typedef struct packed {
		logic [31:14] rsvd;
		logic txf_half;
		logic txf_ready;
		logic txf_err;
		logic rx_line;
		logic tx_line;
		logic busy;
		uart_line_pkg::uart_byte_t data;
	} tx_read_t;

endpackage

`default_nettype wire

/* design/uart_fifo.sv */
// UART byte FIFO
// Circular buffer with a sticky overflow/underflow flag and a status word
// built for either the receive or the transmit side

`timescale 1ns/100ps
`default_nettype none

module uart_fifo
	import uart_line_pkg::*;
#(
	parameter int P_LGFLEN = 4,
	parameter bit P_RXFIFO = 1'b1
) (
	input wire i_clk,
	input wire i_reset,
	input wire i_wr,
	input wire uart_byte_t i_data,
	input wire i_rd,
	output uart_byte_t o_data,
	output logic o_empty_n,
	output fifo_status_t o_status,
	output logic o_err
);

	localparam int DEPTH = 1 << P_LGFLEN;

	uart_byte_t mem [DEPTH];
	logic [P_LGFLEN-1:0] wr_ptr, rd_ptr;
	// one bit wider than the pointers so that full and empty differ
	logic [P_LGFLEN:0] fill;
	logic full, half, do_wr, do_rd;

	assign full = fill[P_LGFLEN];
	assign half = (fill >= (P_LGFLEN+1)'(DEPTH / 2));
	assign o_empty_n = (fill != '0);

	// writes into a full FIFO and reads from an empty one are dropped
	assign do_wr = i_wr && !full;
	assign do_rd = i_rd && o_empty_n;

	always_ff @(posedge i_clk)
		if (do_wr)
			mem[wr_ptr] <= i_data;

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			o_err <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				fill <= fill + 1'b1;
			else if (do_rd && !do_wr)
				fill <= fill - 1'b1;
			// sticky until this FIFO is reset
			if ((i_wr && full) || (i_rd && !o_empty_n))
				o_err <= 1'b1;
		end

	// head of the FIFO, read without a clock so the pop edge sees it
	assign o_data = mem[rd_ptr];

	always_comb
	begin
		o_status.lg_len = 4'(P_LGFLEN);
		if (P_RXFIFO)
		begin
			// receive side reports fill, half means at least half full
			o_status.count = 10'(fill);
			o_status.half = half;
			o_status.ready = o_empty_n;
		end
		else
		begin
			// transmit side reports free space, half means under half full
			o_status.count = 10'((P_LGFLEN+1)'(DEPTH) - fill);
			o_status.half = !half;
			o_status.ready = !full;
		end
	end

endmodule

`default_nettype wire

/* design/uart_rx.sv */
// UART receiver
// Synchronizes the line, finds the start edge and samples each bit in
// its middle, then reports the byte and any framing error for one clock

`timescale 1ns/100ps
`default_nettype none

module uart_rx
	import uart_line_pkg::*;
(
	input wire i_clk,
	input wire i_reset,
	input wire baud_div_t i_div,
	input wire i_uart_rx,
	output rx_event_t o_evt,
	output logic o_ck_uart
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_START = 2'd1;
	localparam logic [1:0] S_DATA = 2'd2;
	localparam logic [1:0] S_STOP = 2'd3;

	logic q_meta, ck_uart;
	logic [1:0] state;
	baud_div_t cnt;
	logic [2:0] bit_idx;
	logic tick;
	uart_byte_t sreg, evt_data;
	logic evt_stb, evt_ferr;

	// two flop synchronizer, idle line is high
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			q_meta <= 1'b1;
			ck_uart <= 1'b1;
		end
		else
		begin
			q_meta <= i_uart_rx;
			ck_uart <= q_meta;
		end

	assign o_ck_uart = ck_uart;

	// a sample point is due in every state but idle
	assign tick = (state != S_IDLE) && (cnt == '0);

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			state <= S_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			evt_stb <= 1'b0;
		end
		else
		begin
			evt_stb <= 1'b0;
			if (state == S_IDLE)
			begin
				// half a bit on from the falling edge lands mid start bit
				if (!ck_uart)
				begin
					state <= S_START;
					cnt <= i_div >> 1;
				end
			end
			else if (!tick)
				cnt <= cnt - 1'b1;
			else
			begin
				cnt <= i_div - 1'b1;
				case (state)
					S_START:
					begin
						// a line back high by mid bit was only a glitch
						state <= ck_uart ? S_IDLE : S_DATA;
						bit_idx <= '0;
					end
					S_DATA:
					begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end
					default:
					begin
						evt_stb <= 1'b1;
						state <= S_IDLE;
					end
				endcase
			end
		end

	// data arrives LSB first, the stop bit sample decides the framing error
	always_ff @(posedge i_clk)
	begin
		if (tick && (state == S_DATA))
			sreg <= {ck_uart, sreg[7:1]};
		if (tick && (state == S_STOP))
		begin
			evt_data <= sreg;
			evt_ferr <= !ck_uart;
		end
	end

	assign o_evt = '{stb: evt_stb, ferr: evt_ferr, data: evt_data};

endmodule

`default_nettype wire

/* design/uart_tx.sv */
// UART transmitter
// Takes a byte from the FIFO head whenever idle and sends it as an 8N1
// frame, start bit first and data LSB first

`timescale 1ns/100ps
`default_nettype none

module uart_tx
	import uart_line_pkg::*;
(
	input wire i_clk,
	input wire i_reset,
	input wire baud_div_t i_div,
	input wire i_empty_n,
	input wire uart_byte_t i_byte,
	output logic o_pop,
	output logic o_uart_tx,
	output logic o_busy
);

	baud_div_t cnt;
	// bits still to shift after the current one, data plus stop
	logic [3:0] nbits;
	logic [8:0] sreg;

	// the byte is taken on the same edge that pops the FIFO
	assign o_pop = !o_busy && i_empty_n;

	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_busy <= 1'b0;
			o_uart_tx <= 1'b1;
			cnt <= '0;
			nbits <= '0;
		end
		else if (!o_busy)
		begin
			if (i_empty_n)
			begin
				// start bit goes out at once
				o_busy <= 1'b1;
				o_uart_tx <= 1'b0;
				cnt <= i_div - 1'b1;
				nbits <= 4'd9;
			end
		end
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
		else if (nbits != '0)
		begin
			o_uart_tx <= sreg[0];
			cnt <= i_div - 1'b1;
			nbits <= nbits - 1'b1;
		end
		else
			// stop bit has run its full time, line stays high
			o_busy <= 1'b0;

	// stop bit sits above the data so it shifts out last
	always_ff @(posedge i_clk)
		if (o_pop)
			sreg <= {1'b1, i_byte};
		else if (o_busy && (cnt == '0) && (nbits != '0))
			sreg <= {1'b1, sreg[8:1]};

endmodule

`default_nettype wire

/* design/uart_regs.sv */
// UART register bank
// Decodes bus strobes into the setup register, FIFO strobes, engine resets
// and the sticky framing error, and returns read data two clocks later

`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module uart_regs
	import uart_line_pkg::*;
	import uart_regs_pkg::*;
(
	input wire i_clk,
	input wire i_reset,
	input wire wb_req_t i_req,
	input wire rx_event_t i_rx_evt,
	input wire uart_byte_t i_rxf_byte,
	input wire fifo_status_t i_rxf_status,
	input wire fifo_status_t i_txf_status,
	input wire i_rxf_err,
	input wire i_txf_err,
	input wire i_tx_busy,
	input wire i_ck_uart,
	input wire i_uart_tx,
	output logic o_ack,
	output logic [31:0] o_data,
	output baud_div_t o_div,
	output logic o_rx_reset,
	output logic o_tx_reset,
	output logic o_rxf_rd,
	output logic o_txf_wr,
	output uart_byte_t o_txf_byte
);

	reg_word_u wr_word;
	logic setup_wr, rx_wr, tx_wr, rx_rd;
	logic r_ferr, r_ack;
	logic [1:0] r_addr;
	setup_word_t rd_setup;
	rx_read_t rd_rx;
	tx_read_t rd_tx;

	//////////////////////////////////////////////////
	// strobe decode
	//////////////////////////////////////////////////

	// the same write word is read as a setup word or as a control word
	assign wr_word = i_req.data;

	assign setup_wr = i_req.stb && i_req.we && (i_req.addr == `UART_ADDR_SETUP);
	assign rx_wr = i_req.stb && i_req.we && (i_req.addr == `UART_ADDR_RXREG);
	assign tx_wr = i_req.stb && i_req.we && (i_req.addr == `UART_ADDR_TXREG);
	assign rx_rd = i_req.stb && !i_req.we && (i_req.addr == `UART_ADDR_RXREG);

	// divisor, byte lanes 0 to 2, the top lane holds nothing
	always_ff @(posedge i_clk)
		if (i_reset)
			o_div <= `UART_DEFAULT_DIV;
		else if (setup_wr)
		begin
			if (i_req.sel[0])
				o_div[7:0] <= wr_word.setup.div[7:0];
			if (i_req.sel[1])
				o_div[15:8] <= wr_word.setup.div[15:8];
			if (i_req.sel[2])
				o_div[23:16] <= wr_word.setup.div[23:16];
		end

	// engine resets, one clock pulses, also raised by any setup write
	always_ff @(posedge i_clk)
	begin
		if (i_reset || setup_wr)
			o_rx_reset <= 1'b1;
		else if (rx_wr && i_req.sel[1])
			o_rx_reset <= wr_word.ctl.rst;
		else
			o_rx_reset <= 1'b0;

		if (i_reset || setup_wr)
			o_tx_reset <= 1'b1;
		else if (tx_wr && i_req.sel[1])
			o_tx_reset <= wr_word.ctl.rst;
		else
			o_tx_reset <= 1'b0;
	end

	// framing error stays set until a receiver reset or a write of 1 to it
	always_ff @(posedge i_clk)
		if (i_reset || o_rx_reset)
			r_ferr <= 1'b0;
		else if (rx_wr && i_req.sel[1])
			r_ferr <= r_ferr && !wr_word.ctl.ferr_clr;
		else if (i_rx_evt.stb && i_rx_evt.ferr)
			r_ferr <= 1'b1;

	// FIFO strobes, registered one clock so byte and strobe line up
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_txf_wr <= 1'b0;
			o_rxf_rd <= 1'b0;
		end
		else
		begin
			o_txf_wr <= tx_wr && i_req.sel[0];
			o_rxf_rd <= rx_rd;
		end

	// last byte written, also returned by a transmit register read
	always_ff @(posedge i_clk)
		if (tx_wr && i_req.sel[0])
			o_txf_byte <= wr_word.ctl.data;

	//////////////////////////////////////////////////
	// acknowledge and read data
	//////////////////////////////////////////////////

	// ack two clocks after the strobe, dropped if the cycle was abandoned
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			r_ack <= 1'b0;
			o_ack <= 1'b0;
		end
		else
		begin
			r_ack <= i_req.stb;
			o_ack <= r_ack && i_req.cyc;
		end

	always_ff @(posedge i_clk)
		r_addr <= i_req.addr;

	always_comb
	begin
		rd_setup = '0;
		rd_setup.div = o_div;

		// the head byte is sampled on the same edge that pops it
		rd_rx = '0;
		rd_rx.fifo_err = i_rxf_err;
		rd_rx.ferr = r_ferr;
		rd_rx.empty = !i_rxf_status.ready;
		rd_rx.data = i_rxf_byte;

		rd_tx = '0;
		rd_tx.txf_half = i_txf_status.half;
		rd_tx.txf_ready = i_txf_status.ready;
		rd_tx.txf_err = i_txf_err;
		rd_tx.rx_line = i_ck_uart;
		rd_tx.tx_line = i_uart_tx;
		rd_tx.busy = i_tx_busy;
		rd_tx.data = o_txf_byte;
	end

	always_ff @(posedge i_clk)
		case (r_addr)
			`UART_ADDR_SETUP: o_data <= rd_setup;
			`UART_ADDR_FIFO: o_data <= {i_txf_status, i_rxf_status};
			`UART_ADDR_RXREG: o_data <= rd_rx;
			`UART_ADDR_TXREG: o_data <= rd_tx;
		endcase

endmodule

`default_nettype wire

/* design/wbuart_top.sv */
// Bus-attached serial port
// Register bank on a pipelined bus, 16-entry receive and transmit FIFOs
// and an 8N1 receiver and transmitter, with four interrupt levels

`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module wbuart_top
	import uart_line_pkg::*;
	import uart_regs_pkg::*;
(
	input wire i_clk,
	input wire i_reset,
	// bus slave
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_we,
	input wire [1:0] i_wb_addr,
	input wire [3:0] i_wb_sel,
	input wire [31:0] i_wb_data,
	output logic o_wb_stall,
	output logic o_wb_ack,
	output logic [31:0] o_wb_data,
	// serial lines
	input wire i_uart_rx,
	output logic o_uart_tx,
	// interrupt levels
	output logic o_uart_rx_int,
	output logic o_uart_rxfifo_int,
	output logic o_uart_tx_int,
	output logic o_uart_txfifo_int
);

	wb_req_t req;
	rx_event_t rx_evt;
	baud_div_t div;
	uart_byte_t rxf_byte, txf_byte, tx_head;
	fifo_status_t rxf_status, txf_status;
	logic rxf_err, txf_err, rxf_rd, txf_wr;
	logic rx_reset, tx_reset;
	logic tx_empty_n, tx_pop, tx_busy, ck_uart;

	assign req = '{cyc: i_wb_cyc, stb: i_wb_stb, we: i_wb_we, addr: i_wb_addr,
		sel: i_wb_sel, data: i_wb_data};

	// every strobe is taken at once, the two clock pipeline never backs up
	assign o_wb_stall = 1'b0;

	// interrupts are straight FIFO status levels
	assign o_uart_rx_int = rxf_status.ready;
	assign o_uart_rxfifo_int = rxf_status.half;
	assign o_uart_tx_int = txf_status.ready;
	assign o_uart_txfifo_int = txf_status.half;

	uart_regs u_regs (
		.i_clk(i_clk), .i_reset(i_reset), .i_req(req), .i_rx_evt(rx_evt),
		.i_rxf_byte(rxf_byte), .i_rxf_status(rxf_status), .i_txf_status(txf_status),
		.i_rxf_err(rxf_err), .i_txf_err(txf_err), .i_tx_busy(tx_busy),
		.i_ck_uart(ck_uart), .i_uart_tx(o_uart_tx),
		.o_ack(o_wb_ack), .o_data(o_wb_data), .o_div(div),
		.o_rx_reset(rx_reset), .o_tx_reset(tx_reset),
		.o_rxf_rd(rxf_rd), .o_txf_wr(txf_wr), .o_txf_byte(txf_byte)
	);

	// the receive FIFO empties on any receiver reset
	uart_fifo #(.P_LGFLEN(`UART_LGFLEN), .P_RXFIFO(1'b1)) u_rxfifo (
		.i_clk(i_clk), .i_reset(rx_reset),
		.i_wr(rx_evt.stb), .i_data(rx_evt.data),
		.i_rd(rxf_rd), .o_data(rxf_byte), .o_empty_n(),
		.o_status(rxf_status), .o_err(rxf_err)
	);

	uart_fifo #(.P_LGFLEN(`UART_LGFLEN), .P_RXFIFO(1'b0)) u_txfifo (
		.i_clk(i_clk), .i_reset(tx_reset),
		.i_wr(txf_wr), .i_data(txf_byte),
		.i_rd(tx_pop), .o_data(tx_head), .o_empty_n(tx_empty_n),
		.o_status(txf_status), .o_err(txf_err)
	);

	uart_rx u_rx (
		.i_clk(i_clk), .i_reset(rx_reset), .i_div(div), .i_uart_rx(i_uart_rx),
		.o_evt(rx_evt), .o_ck_uart(ck_uart)
	);

	uart_tx u_tx (
		.i_clk(i_clk), .i_reset(tx_reset), .i_div(div),
		.i_empty_n(tx_empty_n), .i_byte(tx_head), .o_pop(tx_pop),
		.o_uart_tx(o_uart_tx), .o_busy(tx_busy)
	);

endmodule

`default_nettype wire

/* test/wbuart_chk.sv */
// Serial port checker
// Concurrent assertions on bus acknowledge timing, the stall output, the
// state right after reset and the transmit interrupt, bound into the top level

`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module wbuart_chk (
	input wire i_clk,
	input wire i_reset,
	input wire i_wb_cyc,
	input wire i_wb_stb,
	input wire i_wb_stall,
	input wire i_wb_ack,
	input wire i_uart_tx,
	input wire i_tx_int,
	input wire i_txf_reset,
	input wire i_txf_wr,
	input wire i_txf_rd
);

	localparam int DEPTH = 1 << `UART_LGFLEN;

	// number of assertions that have failed
	int fail_count = 0;

	// transmit FIFO fill as its own write and pop strobes imply
	logic [`UART_LGFLEN:0] txf_fill;
	logic txf_push, txf_pop;

	// a write into a full FIFO and a pop from an empty one change nothing
	assign txf_push = i_txf_wr && (txf_fill != DEPTH);
	assign txf_pop = i_txf_rd && (txf_fill != 0);

	always_ff @(posedge i_clk)
		if (i_txf_reset)
			txf_fill <= '0;
		else if (txf_push && !txf_pop)
			txf_fill <= txf_fill + 1'b1;
		else if (txf_pop && !txf_push)
			txf_fill <= txf_fill - 1'b1;

	//////////////////////////////////////////////////
	// bus timing
	//////////////////////////////////////////////////

	// a strobe whose cycle is still open one clock later is acknowledged two clocks on
	ack_after_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_wb_stb && i_wb_cyc) ##1 i_wb_cyc |=> i_wb_ack)
	else
	begin
		$error("acknowledge missing two clocks after a strobe");
		fail_count++;
	end

	// and never an acknowledge that no strobe asked for
	ack_has_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_ack |-> $past(i_wb_stb, 2))
	else
	begin
		$error("acknowledge without a strobe two clocks earlier");
		fail_count++;
	end

	never_stall: assert property (@(posedge i_clk) !i_wb_stall)
	else
	begin
		$error("stall output went high");
		fail_count++;
	end

	//////////////////////////////////////////////////
	// reset state and interrupts
	//////////////////////////////////////////////////

	// idle line and quiet bus on the first clock out of reset
	reset_state: assert property (@(posedge i_clk) $fell(i_reset) |-> i_uart_tx && !i_wb_ack)
	else
	begin
		$error("serial line low or acknowledge high right after reset");
		fail_count++;
	end

	tx_int_not_full: assert property (@(posedge i_clk) disable iff (i_reset)
		(txf_fill < DEPTH) |-> i_tx_int)
	else
	begin
		$error("transmit interrupt low while the transmit FIFO has room");
		fail_count++;
	end

endmodule

bind wbuart_top wbuart_chk u_chk (
	.i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
	.i_wb_stall(o_wb_stall), .i_wb_ack(o_wb_ack), .i_uart_tx(o_uart_tx),
	.i_tx_int(o_uart_tx_int), .i_txf_reset(tx_reset), .i_txf_wr(txf_wr),
	.i_txf_rd(tx_pop)
);

`default_nettype wire

/* test/tb_wbuart.sv */
// Serial port testbench
// Drives the bus through reset values, loopback traffic, interrupt levels,
// RX FIFO overflow and a bit-banged frame with a bad stop bit

`timescale 1ns/100ps
`default_nettype none

`include "uart_consts.svh"

module tb_wbuart;

	localparam int LOOP_DIV = 8;
	// room for forty ten bit frames at the loopback divisor twice over plus setup time
	localparam int CYCLE_LIMIT = 40 * 10 * LOOP_DIV * 2 + 2000;
	localparam int ACK_LIMIT = 8;
	localparam int DEPTH = 1 << `UART_LGFLEN;
	localparam logic [31:0] RX_EMPTY = 32'h0000_0100;
	localparam logic [31:0] RX_FIFO_ERR = 32'h0000_1000;
	localparam logic [31:0] RX_FERR = 32'(1) << `UART_FERR_BIT;
	localparam logic [31:0] CTL_RST = 32'(1) << `UART_RST_BIT;

	logic i_clk, i_reset;
	logic i_wb_cyc, i_wb_stb, i_wb_we;
	logic [1:0] i_wb_addr;
	logic [3:0] i_wb_sel;
	logic [31:0] i_wb_data;
	logic o_wb_stall, o_wb_ack;
	logic [31:0] o_wb_data;
	logic i_uart_rx, o_uart_tx;
	logic o_uart_rx_int, o_uart_rxfifo_int, o_uart_tx_int, o_uart_txfifo_int;

	logic loopback, gen_line, saw_half;
	logic snap_rx_int, snap_rxfifo_int, snap_tx_int, snap_txfifo_int;
	logic [31:0] rd_data;
	logic [7:0] sent_q [$];
	int errors, bus_errors, cycles, seed;

	// the receiver hears either our own transmitter or the frame generator
	assign i_uart_rx = loopback ? o_uart_tx : gen_line;

	wbuart_top u_dut (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_addr(i_wb_addr), .i_wb_sel(i_wb_sel), .i_wb_data(i_wb_data),
		.o_wb_stall(o_wb_stall), .o_wb_ack(o_wb_ack), .o_wb_data(o_wb_data),
		.i_uart_rx(i_uart_rx), .o_uart_tx(o_uart_tx),
		.o_uart_rx_int(o_uart_rx_int), .o_uart_rxfifo_int(o_uart_rxfifo_int),
		.o_uart_tx_int(o_uart_tx_int), .o_uart_txfifo_int(o_uart_txfifo_int)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
			#10 i_clk = ~i_clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge i_clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycles);
		$display("Testbench failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// expected status words and compares
	//////////////////////////////////////////////////

	// the receive side counts entries and its half flag means at least half full
	function automatic logic [15:0] rx_status(input int fill);
		return {4'(`UART_LGFLEN), 10'(fill), fill >= DEPTH / 2, fill != 0};
	endfunction

	// the transmit side counts free room and its half flag means under half full
	function automatic logic [15:0] tx_status(input int fill);
		return {4'(`UART_LGFLEN), 10'(DEPTH - fill), fill < DEPTH / 2, fill != DEPTH};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp, input logic [31:0] mask);
		if ((got & mask) !== (exp & mask))
		begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got & mask, exp & mask);
		end
	endtask

	//////////////////////////////////////////////////
	// bus access
	//////////////////////////////////////////////////

	// interrupt pins one clock before the ack match the status in the read word
	task automatic wait_ack();
		int waited;
		waited = 0;
		forever
		begin
			@(negedge i_clk);
			if (o_wb_ack)
				break;
			snap_rx_int = o_uart_rx_int;
			snap_rxfifo_int = o_uart_rxfifo_int;
			snap_tx_int = o_uart_tx_int;
			snap_txfifo_int = o_uart_txfifo_int;
			waited++;
			if (waited > ACK_LIMIT)
			begin
				bus_errors++;
				$display("no acknowledge within %0d clocks of a strobe", ACK_LIMIT);
				break;
			end
		end
		rd_data = o_wb_data;
	endtask

	task automatic bus_access(input logic we, input logic [1:0] addr,
		input logic [3:0] sel, input logic [31:0] data);
		@(posedge i_clk);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= we;
		i_wb_addr <= addr;
		i_wb_sel <= sel;
		i_wb_data <= data;
		@(posedge i_clk);
		i_wb_stb <= 1'b0;
		wait_ack();
		@(posedge i_clk);
		i_wb_cyc <= 1'b0;
	endtask

	task automatic bus_write(input logic [1:0] addr, input logic [3:0] sel,
		input logic [31:0] data);
		bus_access(1'b1, addr, sel, data);
	endtask

	task automatic bus_read(input logic [1:0] addr);
		bus_access(1'b0, addr, 4'b1111, 32'h0);
	endtask

	task automatic read_fifo(output int rx_fill, output int tx_free);
		bus_read(`UART_ADDR_FIFO);
		rx_fill = int'(rd_data[11:2]);
		tx_free = int'(rd_data[27:18]);
		check_value("rx status", rd_data, {16'h0, rx_status(rx_fill)}, 32'h0000_ffff);
		check_value("tx status", rd_data, {tx_status(DEPTH - tx_free), 16'h0}, 32'hffff_0000);
		check_value("o_uart_rx_int", {31'h0, snap_rx_int}, {31'h0, rx_fill != 0}, 32'h1);
		check_value("o_uart_rxfifo_int", {31'h0, snap_rxfifo_int},
			{31'h0, rx_fill >= DEPTH / 2}, 32'h1);
		check_value("o_uart_tx_int", {31'h0, snap_tx_int}, {31'h0, tx_free != 0}, 32'h1);
		check_value("o_uart_txfifo_int", {31'h0, snap_txfifo_int},
			{31'h0, (DEPTH - tx_free) < DEPTH / 2}, 32'h1);
		if (snap_rxfifo_int)
			saw_half = 1'b1;
	endtask

	task automatic wait_rx_fill(input int count);
		int fill, tx_free;
		do
			read_fifo(fill, tx_free);
		while (fill < count);
	endtask

	// queue a byte once the transmit FIFO has room
	task automatic send_tx(input logic [7:0] b);
		int fill, tx_free;
		do
			read_fifo(fill, tx_free);
		while (tx_free == 0);
		bus_write(`UART_ADDR_TXREG, 4'b0001, {24'h0, b});
		sent_q.push_back(b);
	endtask

	// start bit, data LSB first, then the given stop bit and two idle bits
	task automatic gen_frame(input logic [7:0] b, input logic stop);
		logic [9:0] bits;
		bits = {stop, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge i_clk);
			gen_line <= bits[i];
			repeat (LOOP_DIV - 1)
				@(posedge i_clk);
		end
		@(posedge i_clk);
		gen_line <= 1'b1;
		repeat (2 * LOOP_DIV)
			@(posedge i_clk);
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial
	begin : main_seq
		int rx_fill, tx_free;
		logic [7:0] b;
		seed = 85230;
		errors = 0;
		bus_errors = 0;
		saw_half = 1'b0;
		snap_rx_int = 1'b0;
		snap_rxfifo_int = 1'b0;
		snap_tx_int = 1'b0;
		snap_txfifo_int = 1'b0;
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_addr = 2'd0;
		i_wb_sel = 4'd0;
		i_wb_data = 32'h0;
		loopback = 1'b0;
		gen_line = 1'b1;
		repeat (4)
			@(posedge i_clk);
		i_reset <= 1'b0;

		// reset values where the underflow from the first RX read shows on the second
		bus_read(`UART_ADDR_SETUP);
		check_value("setup", rd_data, {8'h0, `UART_DEFAULT_DIV}, '1);
		read_fifo(rx_fill, tx_free);
		check_value("fifo", rd_data, {tx_status(0), rx_status(0)}, '1);
		bus_read(`UART_ADDR_RXREG);
		check_value("rxreg", rd_data, RX_EMPTY, 32'hffff_ff00);
		bus_read(`UART_ADDR_RXREG);
		check_value("rxreg", rd_data, RX_EMPTY | RX_FIFO_ERR, 32'hffff_ff00);

		// loopback of ten bytes with the interrupt levels checked on every status read
		bus_write(`UART_ADDR_SETUP, 4'b0111, 32'(LOOP_DIV));
		bus_write(`UART_ADDR_RXREG, 4'b0010, CTL_RST);
		loopback <= 1'b1;
		for (int i = 0; i < 10; i++)
		begin
			b = 8'($random(seed));
			send_tx(b);
		end
		wait_rx_fill(10);
		for (int i = 0; i < 10; i++)
		begin
			bus_read(`UART_ADDR_RXREG);
			check_value("rx byte", rd_data, {24'h0, sent_q.pop_front()}, '1);
		end
		read_fifo(rx_fill, tx_free);
		check_value("rx fill", 32'(rx_fill), 32'd0, '1);
		if (!saw_half)
		begin
			errors++;
			$display("rx half interrupt never rose while ten bytes were waiting");
		end

		// overflow by 18 bytes into a 16 entry FIFO
		for (int i = 0; i < 18; i++)
		begin
			b = 8'($random(seed));
			send_tx(b);
		end
		wait_rx_fill(DEPTH);
		do
			read_fifo(rx_fill, tx_free);
		while (tx_free != DEPTH);
		do
			bus_read(`UART_ADDR_TXREG);
		while (rd_data[8]);
		read_fifo(rx_fill, tx_free);
		check_value("rx fill", 32'(rx_fill), 32'(DEPTH), '1);
		bus_read(`UART_ADDR_RXREG);
		check_value("rx overflow", rd_data, RX_FIFO_ERR | {24'h0, sent_q[0]}, '1);
		bus_write(`UART_ADDR_RXREG, 4'b0010, CTL_RST);
		read_fifo(rx_fill, tx_free);
		check_value("rx fill", 32'(rx_fill), 32'd0, '1);
		bus_read(`UART_ADDR_RXREG);
		check_value("rx after reset", rd_data, RX_EMPTY, 32'hffff_ff00);
		bus_write(`UART_ADDR_RXREG, 4'b0010, CTL_RST);
		sent_q.delete();

		// framing error from a low stop bit that a write of bit 10 clears
		loopback <= 1'b0;
		b = 8'($random(seed));
		gen_frame(b, 1'b0);
		wait_rx_fill(1);
		bus_read(`UART_ADDR_RXREG);
		check_value("framing error", rd_data, RX_FERR | {24'h0, b}, '1);
		bus_write(`UART_ADDR_RXREG, 4'b0010, RX_FERR);
		b = 8'($random(seed));
		gen_frame(b, 1'b1);
		wait_rx_fill(1);
		bus_read(`UART_ADDR_RXREG);
		check_value("good frame", rd_data, {24'h0, b}, '1);

		$display("errors: %0d data, %0d bus, %0d assertion",
			errors, bus_errors, u_dut.u_chk.fail_count);
		if (errors == 0 && bus_errors == 0 && u_dut.u_chk.fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/uart_line_pkg.sv
common/uart_regs_pkg.sv
design/uart_fifo.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_regs.sv
design/wbuart_top.sv
test/wbuart_chk.sv
test/tb_wbuart.sv

/* Makefile */
TOOL      = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = tb_wbuart
FILELIST  = verilog.f
PASS_MSG  = Testbench passed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf obj_dir
